// File: test/regTrace.txt
# skip pcEn pcRst wrEn wrAddr wrData ifIdLoad ifIdFlush instr linkIn, then expected after the edge:
# operandA operandB operandC pc idCond idLink idImm12 idOffset idPc idNextPc (all hex)
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# fill r1 r2 r3 r14
0 0 0 1 1 11111111 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 2 22222222 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 3 33333333 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 1 e eeee0001 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# ADDS r3, r1, r2 latched while r0 is written
0 0 0 1 0 a5a5a5a5 1 0 e0913002 0 11111111 22222222 33333333 0 e 0 002 913002 0 4
0 0 0 1 1 12345678 0 0 0 0 12345678 22222222 33333333 0 e 0 002 913002 0 4
# read r0 r14 r15 while the pc steps
0 1 0 0 0 0 1 0 03a0f00e 0 a5a5a5a5 eeee0001 4 4 0 0 00e a0f00e 0 4
0 1 0 0 0 0 0 0 0 0 a5a5a5a5 eeee0001 8 8 0 0 00e a0f00e 0 4
0 1 0 0 0 0 0 0 0 0 a5a5a5a5 eeee0001 c c 0 0 00e a0f00e 0 4
0 1 1 0 0 0 0 0 0 0 a5a5a5a5 eeee0001 0 0 0 0 00e a0f00e 0 4
0 1 0 0 0 0 0 0 0 0 a5a5a5a5 eeee0001 4 4 0 0 00e a0f00e 0 4
0 1 1 1 f 100 0 0 0 0 a5a5a5a5 eeee0001 100 100 0 0 00e a0f00e 0 4
# BL, then link from linkIn with a same-edge write to r2
0 1 0 0 0 0 1 0 eb00000a 0 a5a5a5a5 0 a5a5a5a5 104 e 1 00a 00000a 100 104
0 0 0 1 2 0f0f0f0f 1 0 11121ff3 1 0f0f0f0f 33333333 12345678 104 1 1 ff3 121ff3 104 108
# flush beats load
0 0 0 0 0 0 1 1 ffffffff 1 a5a5a5a5 a5a5a5a5 a5a5a5a5 104 0 0 0 0 0 0
0 0 0 0 0 0 1 0 24ce2001 0 eeee0001 12345678 0f0f0f0f 104 2 0 001 ce2001 104 108
0 0 0 0 0 0 0 1 0 0 a5a5a5a5 a5a5a5a5 a5a5a5a5 104 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# pc wraps past the top
0 1 0 1 f fffffffc 0 0 0 0 a5a5a5a5 a5a5a5a5 a5a5a5a5 fffffffc 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0 0 a5a5a5a5 a5a5a5a5 a5a5a5a5 0 0 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 a5a5a5a5 a5a5a5a5 a5a5a5a5 0 0 0 0 0 0 0

// File: compile.f
hdl/armPkg.sv
hdl/readPortIf.sv
hdl/pcCounter.sv
hdl/gprBank.sv
hdl/fetchDecodeReg.sv
hdl/decodeRegFile.sv
test/decodeRegFileChk.sv
test/decodeRegFileTb.sv

// File: Makefile
TOP = decodeRegFileTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: test/decodeRegFileTb.sv
/*
  trace-driven testbench for the decode stage, pcStep fixed at 4
  reads test/regTrace.txt from the project root, one line per clock cycle
*/
`timescale 1ns/1ps

module decodeRegFileTb;
  import armPkg::*;

  // skip flag, nine inputs, ten expected outputs
  localparam int fieldCount = 20;
  localparam int maxLines = 256;
  localparam int clkPeriod = 20;

  logic clk;
  logic clr;
  logic pcEnable;
  logic pcReset;
  logic wrEnable;
  logic [regAddrWidth-1:0] wrAddr;
  logic [dataWidth-1:0] wrData;
  logic ifIdLoad;
  logic ifIdFlush;
  logic [dataWidth-1:0] instr;
  logic linkIn;
  logic [dataWidth-1:0] operandA;
  logic [dataWidth-1:0] operandB;
  logic [dataWidth-1:0] operandC;
  logic [dataWidth-1:0] pc;
  logic [dataWidth-1:0] idPc;
  logic [dataWidth-1:0] idNextPc;
  logic idLink;
  logic [3:0] idCond;
  logic idSBit;
  logic [regAddrWidth-1:0] idRdNum;
  logic [11:0] idImm12;
  logic [23:0] idOffset;

  // parsed trace rows
  logic [31:0] trace [0:maxLines-1][0:fieldCount-1];
  int lineCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int totalErrors;
  logic loaded = 1'b0;
  // instruction word IF/ID should hold, from the trace inputs
  logic [dataWidth-1:0] heldInstr = '0;

  decodeRegFile #(
    .pcStep(4)
  ) dut0 (
    .clk(clk),
    .clr(clr),
    .pcEnable(pcEnable),
    .pcReset(pcReset),
    .wrEnable(wrEnable),
    .wrAddr(wrAddr),
    .wrData(wrData),
    .ifIdLoad(ifIdLoad),
    .ifIdFlush(ifIdFlush),
    .instr(instr),
    .linkIn(linkIn),
    .operandA(operandA),
    .operandB(operandB),
    .operandC(operandC),
    .pc(pc),
    .idPc(idPc),
    .idNextPc(idNextPc),
    .idLink(idLink),
    .idCond(idCond),
    .idSBit(idSBit),
    .idRdNum(idRdNum),
    .idImm12(idImm12),
    .idOffset(idOffset)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic loadTrace();
    int fd;
    int got;
    int lineNo;
    string line;
    logic [31:0] f [0:fieldCount-1];
    fd = $fopen("test/regTrace.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open the trace file test/regTrace.txt");
      errorCount++;
      return;
    end
    lineNo = 0;
    while (!$feof(fd))
    begin
      line = "";
      got = $fgets(line, fd);
      lineNo++;
      // blank and comment lines
      if (got == 0 || line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r")
        continue;
      got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
      if (got != fieldCount)
      begin
        $display("Trace line %0d has %0d fields, %0d are needed", lineNo, got, fieldCount);
        errorCount++;
      end
      else if (lineCount == maxLines)
      begin
        $display("Trace file holds more than %0d cycles", maxLines);
        errorCount++;
      end
      else
      begin
        for (int i = 0; i < fieldCount; i++)
          trace[lineCount][i] = f[i];
        lineCount++;
      end
    end
    $fclose(fd);
    if (lineCount == 0)
    begin
      $display("Trace file holds no cycles");
      errorCount++;
    end
  endtask

  task automatic applyInputs(input int row);
    pcEnable = trace[row][1][0];
    pcReset = trace[row][2][0];
    wrEnable = trace[row][3][0];
    wrAddr = trace[row][4][regAddrWidth-1:0];
    wrData = trace[row][5];
    ifIdLoad = trace[row][6][0];
    ifIdFlush = trace[row][7][0];
    instr = trace[row][8];
    linkIn = trace[row][9][0];
  endtask

  // flush clears the held word, otherwise load takes the new one
  task automatic trackIfId(input int row);
    if (trace[row][7][0])
      heldInstr = '0;
    else if (trace[row][6][0])
      heldInstr = trace[row][8];
  endtask

  task automatic checkOutputs(input int row);
    checkValue("operandA", operandA, trace[row][10]);
    checkValue("operandB", operandB, trace[row][11]);
    checkValue("operandC", operandC, trace[row][12]);
    checkValue("pc", pc, trace[row][13]);
    checkValue("idCond", 32'(idCond), trace[row][14]);
    checkValue("idLink", 32'(idLink), trace[row][15]);
    checkValue("idImm12", 32'(idImm12), trace[row][16]);
    checkValue("idOffset", 32'(idOffset), trace[row][17]);
    checkValue("idPc", idPc, trace[row][18]);
    checkValue("idNextPc", idNextPc, trace[row][19]);
    // S bit is word bit 20, rd is bits 15:12
    checkValue("idSBit", 32'(idSBit), 32'(heldInstr[20]));
    checkValue("idRdNum", 32'(idRdNum), 32'(heldInstr[15:12]));
  endtask

  // watchdog, trace length plus ten cycles
  initial
  begin
    wait (loaded);
    repeat (lineCount + 10) #clkPeriod;
    $display("Watchdog expired: the trace did not finish within %0d cycles", lineCount + 10);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial
  begin
    clr = 1'b0;
    pcEnable = 1'b0;
    pcReset = 1'b0;
    wrEnable = 1'b0;
    wrAddr = '0;
    wrData = '0;
    ifIdLoad = 1'b0;
    ifIdFlush = 1'b0;
    instr = '0;
    linkIn = 1'b0;
    loadTrace();
    loaded = 1'b1;
    if (errorCount == 0)
    begin
      // three cycles in reset, release off the edge
      repeat (3) @(posedge clk);
      #2;
      clr = 1'b1;
      for (int row = 0; row < lineCount; row++)
      begin
        applyInputs(row);
        @(posedge clk);
        trackIfId(row);
        // outputs settled after the edge
        #1;
        if (trace[row][0] == 0)
          checkOutputs(row);
        #1;
      end
    end
    totalErrors = errorCount + dut0.chk0.assertFails;
    $display("checks %0d, mismatches %0d, assertion failures %0d",
             checkCount, errorCount, dut0.chk0.assertFails);
    if (totalErrors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: test/decodeRegFileChk.sv
/*
  pc assertions bound into the decode stage top
  step and load checks are off while clr is low
*/
`timescale 1ns/1ps

module decodeRegFileChk #(
  parameter int pcStep = 4
) (
  input logic                             clk,
  input logic                             clr,
  input logic                             pcEnable,
  input logic                             pcReset,
  input logic                             wrEnable,
  input logic [armPkg::regAddrWidth-1:0]  wrAddr,
  input logic [armPkg::dataWidth-1:0]     wrData,
  input logic [armPkg::dataWidth-1:0]     pc
);
  import armPkg::*;

  // failure tally, read by the testbench
  int assertFails = 0;
  // write port aimed at r15
  logic pcWrite;

  assign pcWrite = wrEnable && (wrAddr == regAddrWidth'(pcIndex));

  pcZeroInReset: assert property (@(posedge clk) !clr |-> pc == '0)
  else
  begin
    assertFails++;
    $error("pc is not zero while clr is low");
  end

  // only pcEnable active, plain step
  pcStepWhenEnabled: assert property (
    @(posedge clk) disable iff (!clr)
    (pcEnable && !pcReset && !pcWrite) |=> (pc == $past(pc) + dataWidth'(pcStep)))
  else
  begin
    assertFails++;
    $error("pc did not advance by pcStep");
  end

  // r15 write wins over reset and step
  pcLoadOnWrite: assert property (
    @(posedge clk) disable iff (!clr)
    pcWrite |=> (pc == $past(wrData)))
  else
  begin
    assertFails++;
    $error("pc did not take the value written to r15");
  end

endmodule

bind decodeRegFile decodeRegFileChk #(
  .pcStep(pcStep)
) chk0 (
  .clk(clk),
  .clr(clr),
  .pcEnable(pcEnable),
  .pcReset(pcReset),
  .wrEnable(wrEnable),
  .wrAddr(wrAddr),
  .wrData(wrData),
  .pc(pc)
);

// File: hdl/decodeRegFile.sv
/*
  decode stage top: IF/ID register driving the register-file read ports
  writes and IF/ID loads become visible one edge later
*/
`timescale 1ns/1ps

module decodeRegFile #(
  parameter int pcStep = 4
) (
  input  logic                             clk,
  input  logic                             clr,
  input  logic                             pcEnable,
  input  logic                             pcReset,
  input  logic                             wrEnable,
  input  logic [armPkg::regAddrWidth-1:0]  wrAddr,
  input  logic [armPkg::dataWidth-1:0]     wrData,
  input  logic                             ifIdLoad,
  input  logic                             ifIdFlush,
  input  logic [armPkg::dataWidth-1:0]     instr,
  input  logic                             linkIn,
  output logic [armPkg::dataWidth-1:0]     operandA,
  output logic [armPkg::dataWidth-1:0]     operandB,
  output logic [armPkg::dataWidth-1:0]     operandC,
  output logic [armPkg::dataWidth-1:0]     pc,
  output logic [armPkg::dataWidth-1:0]     idPc,
  output logic [armPkg::dataWidth-1:0]     idNextPc,
  output logic                             idLink,
  output logic [3:0]                       idCond,
  output logic                             idSBit,
  output logic [armPkg::regAddrWidth-1:0]  idRdNum,
  output logic [11:0]                      idImm12,
  output logic [23:0]                      idOffset
);
  import armPkg::*;

  // pc plus step into IF/ID
  logic [dataWidth-1:0] nextPc;

  // IF/ID to bank read ports
  readPortIf rdPort ();

  pcCounter #(
    .pcStep(pcStep)
  ) pcCounter0 (
    .clk(clk),
    .clr(clr),
    .pcEnable(pcEnable),
    .pcReset(pcReset),
    .wrEnable(wrEnable),
    .wrAddr(wrAddr),
    .wrData(wrData),
    .pc(pc),
    .nextPc(nextPc)
  );

  gprBank gprBank0 (
    .clk(clk),
    .clr(clr),
    .wrEnable(wrEnable),
    .wrAddr(wrAddr),
    .wrData(wrData),
    .pc(pc),
    .rd(rdPort.bank)
  );

  fetchDecodeReg fetchDecodeReg0 (
    .clk(clk),
    .clr(clr),
    .ifIdLoad(ifIdLoad),
    .ifIdFlush(ifIdFlush),
    .instr(instr),
    .pc(pc),
    .nextPc(nextPc),
    .linkIn(linkIn),
    .rd(rdPort.decode),
    .idPc(idPc),
    .idNextPc(idNextPc),
    .idLink(idLink),
    .idCond(idCond),
    .idSBit(idSBit),
    .idRdNum(idRdNum),
    .idImm12(idImm12),
    .idOffset(idOffset)
  );

  // operands out as plain ports
  assign operandA = rdPort.dataA;
  assign operandB = rdPort.dataB;
  assign operandC = rdPort.dataC;

endmodule

// File: hdl/fetchDecodeReg.sv
/*
  IF/ID register; flush wins over load, both act at the clock edge
  idLink is set by linkIn or by a BL word (class 101, bit 24)
*/
`timescale 1ns/1ps

module fetchDecodeReg (
  input  logic                             clk,
  input  logic                             clr,
  input  logic                             ifIdLoad,
  input  logic                             ifIdFlush,
  input  logic [armPkg::dataWidth-1:0]     instr,
  input  logic [armPkg::dataWidth-1:0]     pc,
  input  logic [armPkg::dataWidth-1:0]     nextPc,
  input  logic                             linkIn,
  readPortIf.decode                        rd,
  output logic [armPkg::dataWidth-1:0]     idPc,
  output logic [armPkg::dataWidth-1:0]     idNextPc,
  output logic                             idLink,
  output logic [3:0]                       idCond,
  output logic                             idSBit,
  output logic [armPkg::regAddrWidth-1:0]  idRdNum,
  output logic [11:0]                      idImm12,
  output logic [23:0]                      idOffset
);
  import armPkg::*;

  // held instruction word
  instrWordT instrQ;
  // held link flag from fetch
  logic linkQ;
  // branch class in the ARM encoding
  logic isBranch;

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      instrQ <= '0;
      idPc <= '0;
      idNextPc <= '0;
      linkQ <= 1'b0;
    end
    // bubble, clears every held field
    else if (ifIdFlush)
    begin
      instrQ <= '0;
      idPc <= '0;
      idNextPc <= '0;
      linkQ <= 1'b0;
    end
    else if (ifIdLoad)
    begin
      instrQ <= instr;
      idPc <= pc;
      idNextPc <= nextPc;
      linkQ <= linkIn;
    end
  end

  // register numbers straight to the read ports
  assign rd.addrA = instrQ.dataProc.rn;
  assign rd.addrB = instrQ.dataProc.operand2[3:0];
  assign rd.addrC = instrQ.dataProc.rd;

  // register-operand view
  assign idCond = instrQ.dataProc.condition;
  assign idSBit = instrQ.dataProc.sBit;
  assign idRdNum = instrQ.dataProc.rd;
  assign idImm12 = instrQ.dataProc.operand2;

  // branch view
  assign isBranch = (instrQ.branch.instrClass == 3'b101);
  assign idOffset = instrQ.branch.offset;
  assign idLink = linkQ || (isBranch && instrQ.branch.link);

endmodule

// File: hdl/gprBank.sv
/*
  r0 to r14 with one write port and three read ports
  r15 reads back the pc; a write to r15 leaves the bank untouched
*/
`timescale 1ns/1ps

module gprBank (
  input  logic                             clk,
  input  logic                             clr,
  input  logic                             wrEnable,
  input  logic [armPkg::regAddrWidth-1:0]  wrAddr,
  input  logic [armPkg::dataWidth-1:0]     wrData,
  input  logic [armPkg::dataWidth-1:0]     pc,
  readPortIf.bank                          rd
);
  import armPkg::*;

  // general registers, index = register number
  logic [pcIndex-1:0][dataWidth-1:0] gpr;
  // one-hot load enables, none for r15
  logic [pcIndex-1:0] loadEn;
  // all sixteen read sources, pc on top
  logic [regCount-1:0][dataWidth-1:0] readSrc;

  // write decode
  always_comb
  begin
    for (int i = 0; i < pcIndex; i++)
    begin
      loadEn[i] = wrEnable && (wrAddr == regAddrWidth'(i));
    end
  end

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      gpr <= '0;
    end
    else
    begin
      for (int i = 0; i < pcIndex; i++)
      begin
        if (loadEn[i])
        begin
          gpr[i] <= wrData;
        end
      end
    end
  end

  // source 15 is the live pc
  assign readSrc = {pc, gpr};

  // three 16-way selectors
  assign rd.dataA = readSrc[rd.addrA];
  assign rd.dataB = readSrc[rd.addrB];
  assign rd.dataC = readSrc[rd.addrC];

endmodule

// File: hdl/pcCounter.sv
/*
  register 15, the pc; priority is write to r15, then pcReset, then step
  pcStep wraps modulo 2**32, no alignment check on loaded values
*/
`timescale 1ns/1ps

module pcCounter #(
  parameter int pcStep = 4
) (
  input  logic                             clk,
  input  logic                             clr,
  input  logic                             pcEnable,
  input  logic                             pcReset,
  input  logic                             wrEnable,
  input  logic [armPkg::regAddrWidth-1:0]  wrAddr,
  input  logic [armPkg::dataWidth-1:0]     wrData,
  output logic [armPkg::dataWidth-1:0]     pc,
  output logic [armPkg::dataWidth-1:0]     nextPc
);
  import armPkg::*;

  // write port aimed at r15
  logic pcLoad;

  assign pcLoad = wrEnable && (wrAddr == regAddrWidth'(pcIndex));

  // sequential address, also latched by IF/ID
  assign nextPc = pc + dataWidth'(pcStep);

  always_ff @(posedge clk or negedge clr)
  begin
    if (!clr)
    begin
      pc <= '0;
    end
    // register write beats everything
    else if (pcLoad)
    begin
      pc <= wrData;
    end
    // synchronous return to zero
    else if (pcReset)
    begin
      pc <= '0;
    end
    else if (pcEnable)
    begin
      pc <= nextPc;
    end
  end

endmodule

// File: hdl/readPortIf.sv
/*
  three combinational read ports, no handshake
  data follow the addresses in the same cycle
*/
`timescale 1ns/1ps

interface readPortIf;
  import armPkg::*;

  // register numbers from IF/ID
  logic [regAddrWidth-1:0] addrA;
  logic [regAddrWidth-1:0] addrB;
  logic [regAddrWidth-1:0] addrC;
  // operands back from the bank
  logic [dataWidth-1:0] dataA;
  logic [dataWidth-1:0] dataB;
  logic [dataWidth-1:0] dataC;

  modport decode (output addrA, addrB, addrC, input dataA, dataB, dataC);
  modport bank (input addrA, addrB, addrC, output dataA, dataB, dataC);

endinterface

// File: hdl/armPkg.sv
/*
  shared register-file constants and the 32-bit instruction word views
  only data-processing and branch encodings are decoded
*/
package armPkg;

  // register and instruction word width
  localparam int dataWidth = 32;
  // fifteen general registers plus the pc
  localparam int regCount = 16;
  localparam int regAddrWidth = 4;
  // register number that names the pc
  localparam int pcIndex = 15;

  // register-operand view
  typedef struct packed {
    logic [3:0]  condition;
    logic [2:0]  instrClass;
    logic [3:0]  opcode;
    logic        sBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    // rm sits in the low nibble
    logic [11:0] operand2;
  } dataProcT;

  // branch view
  typedef struct packed {
    logic [3:0]  condition;
    logic [2:0]  instrClass;
    logic        link;
    // word offset, sign extension happens later
    logic [23:0] offset;
  } branchT;

  // one fetched word, read both ways
  typedef union packed {
    dataProcT dataProc;
    branchT   branch;
  } instrWordT;

endpackage
